// ==== gfx_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// drawing types shared by the line engine and the framebuffer
// coordinates are signed so that clipped lines can start off screen
// ~~~~~~~~~~~~~~~~~~~~

package gfx_pkg;

    localparam int CORDW = 16;  // coordinate width
    localparam int CIDXW = 4;   // colour index width

    typedef logic signed [CORDW-1:0] coord_t;
    typedef logic [CIDXW-1:0] cidx_t;

    // one line as set up by the host
    typedef struct packed {
        coord_t x0;
        coord_t y0;
        coord_t x1;
        coord_t y1;
        cidx_t  cidx;
    } line_cmd_t;

    // one pixel from the engine to the framebuffer
    typedef struct packed {
        logic   valid;
        coord_t x;
        coord_t y;
        cidx_t  cidx;
    } pix_wr_t;

endpackage

// ==== apb_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// APB bus structs and the register map of the line accelerator
// 16-bit byte addresses, 32-bit data
// ~~~~~~~~~~~~~~~~~~~~

package apb_pkg;

    typedef struct packed {
        logic [15:0] paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    localparam logic [15:0] REG_P0   = 16'h0000;  // {y0, x0}
    localparam logic [15:0] REG_P1   = 16'h0004;  // {y1, x1}
    localparam logic [15:0] REG_CTRL = 16'h0008;  // wr: colour, start, clear; rd: busy
    localparam logic [15:0] PIX_BASE = 16'h1000;  // pixel window, one word per pixel

    // control register bit positions
    localparam int CTRL_START = 8;
    localparam int CTRL_CLEAR = 9;

endpackage

// ==== line_cmd_decode.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// APB register block; pixel window must fit below 0x10000
// start and clear are refused with pslverr while anything is busy
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module line_cmd_decode import gfx_pkg::*, apb_pkg::*; #(
    parameter int FB_W = 64,
    parameter int FB_H = 64
) (
    input  logic                             clk_100m,
    input  logic                             rst_n,
    input  apb_req_t                         apb_req,
    output apb_rsp_t                         apb_rsp,
    output line_cmd_t                        cmd,
    output logic                             start,
    output logic                             clear,
    output logic [$clog2(FB_W * FB_H)-1:0]   rd_addr,
    input  cidx_t                            rd_data,
    input  logic                             draw_busy,
    input  logic                             clear_busy
);

    localparam int AW = $clog2(FB_W * FB_H);
    localparam logic [15:0] PIX_END = 16'(PIX_BASE + 4 * FB_W * FB_H);

    logic        access;      // access phase of a transfer
    logic        hit_p0, hit_p1, hit_ctrl, hit_pix, unmapped;
    logic        pix_wait;    // pixel read wait state done
    logic        ctrl_cmd;    // ctrl write asking for start or clear
    logic        busy_any;
    logic        refused;
    logic        wr_ok;
    logic [15:0] pix_off;

    always_comb begin
        access   = apb_req.psel & apb_req.penable;
        hit_p0   = apb_req.paddr == REG_P0;
        hit_p1   = apb_req.paddr == REG_P1;
        hit_ctrl = apb_req.paddr == REG_CTRL;
        hit_pix  = apb_req.paddr >= PIX_BASE && apb_req.paddr < PIX_END;
        unmapped = !(hit_p0 || hit_p1 || hit_ctrl || hit_pix);

        busy_any = draw_busy | clear_busy;
        ctrl_cmd = hit_ctrl & apb_req.pwrite
                 & (apb_req.pwdata[CTRL_START] | apb_req.pwdata[CTRL_CLEAR]);
        refused  = ctrl_cmd & busy_any;
        wr_ok    = access & apb_req.pwrite & ~hit_pix & ~refused;

        pix_off  = apb_req.paddr - PIX_BASE;
        rd_addr  = pix_off[AW+1:2];  // word index = y*FB_W + x
    end

    always_comb begin
        apb_rsp.pready  = access & (~hit_pix | pix_wait);
        apb_rsp.pslverr = apb_rsp.pready & (unmapped | refused);
        apb_rsp.prdata  = '0;  // unmapped reads return zero
        if (hit_p0) begin
            apb_rsp.prdata = {cmd.y0, cmd.x0};
        end else if (hit_p1) begin
            apb_rsp.prdata = {cmd.y1, cmd.x1};
        end else if (hit_ctrl) begin
            apb_rsp.prdata = {31'b0, busy_any};
        end else if (hit_pix) begin
            apb_rsp.prdata = {{(32 - CIDXW){1'b0}}, rd_data};
        end
    end

    // command pulses and the pixel read wait state
    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            start    <= 1'b0;
            clear    <= 1'b0;
            pix_wait <= 1'b0;
        end else begin
            // clear wins if both bits are set
            start    <= wr_ok & hit_ctrl & apb_req.pwdata[CTRL_START]
                      & ~apb_req.pwdata[CTRL_CLEAR];
            clear    <= wr_ok & hit_ctrl & apb_req.pwdata[CTRL_CLEAR];
            pix_wait <= access & hit_pix & ~pix_wait;
        end
    end

    // line registers
    always_ff @(posedge clk_100m) begin
        if (wr_ok && hit_p0) begin
            cmd.x0 <= apb_req.pwdata[15:0];
            cmd.y0 <= apb_req.pwdata[31:16];
        end
        if (wr_ok && hit_p1) begin
            cmd.x1 <= apb_req.pwdata[15:0];
            cmd.y1 <= apb_req.pwdata[31:16];
        end
        if (wr_ok && hit_ctrl) begin
            cmd.cidx <= apb_req.pwdata[CIDXW-1:0];
        end
    end

endmodule

// ==== draw_line.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Bresenham line engine, all octants, one pixel per cycle
// start is ignored while busy; no clipping here
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module draw_line import gfx_pkg::*; (
    input  logic      clk_100m,
    input  logic      rst_n,
    input  line_cmd_t cmd,
    input  logic      start,
    output pix_wr_t   pix,
    output logic      busy
);

    typedef enum logic [1:0] {
        IDLE,
        INIT,
        DRAW
    } state_t;

    state_t state;

    coord_t x, y;     // current pixel
    coord_t xe, ye;   // end point
    cidx_t  cidx;
    logic signed [CORDW:0]   dx, dy;           // dy is kept negative
    logic signed [CORDW:0]   dx_raw, dy_raw;
    logic signed [CORDW:0]   abs_dx, neg_dy;
    logic signed [CORDW+1:0] err;
    logic signed [CORDW+2:0] e2;
    logic sx, sy;     // step towards smaller coordinate
    logic at_end;
    logic step_x, step_y;

    always_comb begin
        dx_raw = (CORDW+1)'(xe) - (CORDW+1)'(x);
        dy_raw = (CORDW+1)'(ye) - (CORDW+1)'(y);
        abs_dx = dx_raw[CORDW] ? -dx_raw : dx_raw;
        neg_dy = dy_raw[CORDW] ? dy_raw : -dy_raw;

        e2     = (CORDW+3)'(err) <<< 1;
        step_x = e2 >= dy;
        step_y = e2 <= dx;
        at_end = (x == xe) && (y == ye);
    end

    // control
    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (start) state <= INIT;
                INIT: state <= DRAW;
                DRAW: if (at_end) state <= IDLE;  // end point just emitted
                default: state <= IDLE;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk_100m) begin
        case (state)
            IDLE: begin
                if (start) begin
                    x    <= cmd.x0;
                    y    <= cmd.y0;
                    xe   <= cmd.x1;
                    ye   <= cmd.y1;
                    cidx <= cmd.cidx;
                end
            end
            INIT: begin
                dx  <= abs_dx;
                dy  <= neg_dy;
                sx  <= dx_raw[CORDW];
                sy  <= dy_raw[CORDW];
                err <= (CORDW+2)'(abs_dx) + (CORDW+2)'(neg_dy);
            end
            DRAW: begin
                if (!at_end) begin
                    if (step_x) x <= sx ? x - 1'b1 : x + 1'b1;
                    if (step_y) y <= sy ? y - 1'b1 : y + 1'b1;
                    // both corrections may apply in the same step
                    err <= err + (step_x ? (CORDW+2)'(dy) : '0)
                               + (step_y ? (CORDW+2)'(dx) : '0);
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        busy      = state != IDLE;
        pix.valid = state == DRAW;
        pix.x     = x;
        pix.y     = y;
        pix.cidx  = cidx;
    end

endmodule

// ==== pixel_store.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// indexed-colour framebuffer; FB_W and FB_H powers of two, at least 2
// contents undefined until the first clear
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module pixel_store import gfx_pkg::*; #(
    parameter int FB_W = 64,
    parameter int FB_H = 64
) (
    input  logic                           clk_100m,
    input  logic                           rst_n,
    input  pix_wr_t                        pix,
    input  logic                           clear,
    output logic                           clear_busy,
    input  logic [$clog2(FB_W * FB_H)-1:0] rd_addr,
    output cidx_t                          rd_data
);

    localparam int N  = FB_W * FB_H;
    localparam int AW = $clog2(N);
    localparam int XW = $clog2(FB_W);

    cidx_t mem [N];

    logic [AW-1:0] clr_addr;  // clear sweep position
    logic          in_range;
    logic          we;
    logic [AW-1:0] wr_addr;
    cidx_t         wr_data;

    always_comb begin
        in_range = pix.x >= 0 && pix.x < FB_W && pix.y >= 0 && pix.y < FB_H;
        we       = clear_busy | (pix.valid & in_range);
        wr_addr  = clear_busy ? clr_addr : {pix.y[AW-XW-1:0], pix.x[XW-1:0]};
        wr_data  = clear_busy ? '0 : pix.cidx;
    end

    // clear sweep, one location per cycle
    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            clear_busy <= 1'b0;
            clr_addr   <= '0;
        end else if (clear && !clear_busy) begin
            clear_busy <= 1'b1;
            clr_addr   <= '0;
        end else if (clear_busy) begin
            clr_addr <= clr_addr + 1'b1;  // wraps back to 0
            if (clr_addr == AW'(N - 1)) clear_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk_100m) begin
        if (we) mem[wr_addr] <= wr_data;
    end

    // registered read port
    always_ff @(posedge clk_100m) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== line_draw_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// line accelerator top; APB only, single clock domain
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module line_draw_top import gfx_pkg::*, apb_pkg::*; #(
    parameter int FB_W = 64,
    parameter int FB_H = 64
) (
    input  logic     clk_100m,
    input  logic     rst_n,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    line_cmd_t                        cmd;
    logic                             start;
    logic                             clear;
    logic [$clog2(FB_W * FB_H)-1:0]   rd_addr;
    cidx_t                            rd_data;
    logic                             draw_busy;
    logic                             clear_busy;
    pix_wr_t                          pix;

    line_cmd_decode #(
        .FB_W(FB_W),
        .FB_H(FB_H)
    ) line_cmd_decode_i (
        .clk_100m,
        .rst_n,
        .apb_req,
        .apb_rsp,
        .cmd,
        .start,
        .clear,
        .rd_addr,
        .rd_data,
        .draw_busy,
        .clear_busy
    );

    draw_line draw_line_i (
        .clk_100m,
        .rst_n,
        .cmd,
        .start,
        .pix,
        .busy(draw_busy)
    );

    pixel_store #(
        .FB_W(FB_W),
        .FB_H(FB_H)
    ) pixel_store_i (
        .clk_100m,
        .rst_n,
        .pix,
        .clear,
        .clear_busy,
        .rd_addr,
        .rd_data
    );

endmodule

// ==== line_draw_assertions.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// APB and busy checks, bound into line_cmd_decode
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module line_draw_assertions import apb_pkg::*; (
    input logic     clk_100m,
    input logic     rst_n,
    input apb_req_t apb_req,
    input apb_rsp_t apb_rsp,
    input logic     start,
    input logic     clear,
    input logic     draw_busy,
    input logic     clear_busy
);

    int fail_count = 0;  // read by the testbench at the end

    ready_in_access: assert property (@(posedge clk_100m) disable iff (!rst_n)
        apb_rsp.pready |-> apb_req.psel && apb_req.penable)
        else begin
            fail_count++;
            $error("pready high outside an APB access phase");
        end

    err_with_ready: assert property (@(posedge clk_100m) disable iff (!rst_n)
        apb_rsp.pslverr |-> apb_rsp.pready)
        else begin
            fail_count++;
            $error("pslverr high without pready");
        end

    no_cmd_when_busy: assert property (@(posedge clk_100m) disable iff (!rst_n)
        (start || clear) |-> !(draw_busy || clear_busy))
        else begin
            fail_count++;
            $error("start or clear issued while busy");
        end

endmodule

bind line_cmd_decode line_draw_assertions line_draw_assertions_i (.*);

// ==== line_draw_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// replays line_patterns.txt over APB; default 64x64 framebuffer
// run from the project root so the pattern file is found
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module line_draw_tb import apb_pkg::*; ();

    localparam int FB_W       = 64;
    localparam int FB_H       = 64;
    localparam int XFER_LIMIT = 100;    // cycles to wait for pready
    localparam int POLL_LIMIT = 10000;  // status reads before giving up

    logic        clk_100m;
    logic        rst_n;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;

    int          errors;
    int          test_errs;
    int          tests_done;
    bit          hung;
    logic [31:0] rng;
    logic [31:0] last_rdata;

    line_draw_top line_draw_top_i (
        .clk_100m,
        .rst_n,
        .apb_req,
        .apb_rsp
    );

    always #5 clk_100m = ~clk_100m;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic note_mismatch(input string msg);
        $display("mismatch at %0t: %s", $time, msg);
        errors++;
        test_errs++;
    endtask

    task automatic report_test(input int num);
        $display("test %0d %s, %0d errors", num, test_errs == 0 ? "ok" : "failed", test_errs);
        tests_done++;
        test_errs = 0;
    endtask

    // one APB transfer; entered 1 ns after a rising edge
    task automatic do_xfer(input logic wr, input logic [15:0] addr, input logic [31:0] data,
                           input logic exp_err, input logic chk_data);
        int waits;
        int exp_waits;
        exp_waits = (!wr && addr >= PIX_BASE) ? 1 : 0;  // pixel reads wait once
        apb_req   = {addr, 1'b1, 1'b0, wr, data};
        @(posedge clk_100m);
        #1 apb_req.penable = 1'b1;
        waits = 0;
        @(negedge clk_100m);  // outputs settled mid-cycle
        while (!apb_rsp.pready && waits < XFER_LIMIT) begin
            waits++;
            @(negedge clk_100m);
        end
        last_rdata = apb_rsp.prdata;
        if (!apb_rsp.pready) begin
            $display("no pready for address %h after %0d cycles", addr, XFER_LIMIT);
            hung = 1'b1;
        end else begin
            if (apb_rsp.pslverr !== exp_err)
                note_mismatch($sformatf("pslverr %b at %h, expected %b",
                                        apb_rsp.pslverr, addr, exp_err));
            if (chk_data && last_rdata !== data)
                note_mismatch($sformatf("read %h from %h, expected %h", last_rdata, addr, data));
            if (waits != exp_waits)
                note_mismatch($sformatf("%0d wait states at %h, expected %0d",
                                        waits, addr, exp_waits));
        end
        @(posedge clk_100m);
        #1 apb_req = '0;
    endtask

    initial begin
        int          fd;
        int          cur_test;
        int          num;
        int          polls;
        string       line;
        string       op;
        logic [31:0] addr;
        logic [31:0] val;
        clk_100m   = 1'b0;
        rst_n      = 1'b0;
        apb_req    = '0;
        errors     = 0;
        test_errs  = 0;
        tests_done = 0;
        hung       = 1'b0;
        rng        = 32'hea55_a022;
        cur_test   = 0;
        repeat (2) @(posedge clk_100m);
        #1 rst_n = 1'b1;
        fd = $fopen("line_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open line_patterns.txt");
            hung = 1'b1;
        end
        while (!hung && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            if ($sscanf(line, "%s %h %h %d", op, addr, val, num) != 4) continue;
            if (num != cur_test) begin
                if (cur_test != 0) report_test(cur_test);
                cur_test = num;
            end
            if (op == "W") begin
                do_xfer(1'b1, addr[15:0], val, 1'b0, 1'b0);
            end else if (op == "E") begin
                do_xfer(1'b1, addr[15:0], val, 1'b1, 1'b0);
            end else if (op == "R") begin
                do_xfer(1'b0, addr[15:0], val, 1'b0, 1'b1);
            end else if (op == "N") begin
                do_xfer(1'b0, addr[15:0], val, 1'b1, 1'b1);
            end else if (op == "P") begin
                polls      = 0;
                last_rdata = 32'h1;
                while (last_rdata[0] && !hung && polls < POLL_LIMIT) begin
                    do_xfer(1'b0, REG_CTRL, '0, 1'b0, 1'b0);
                    polls++;
                end
                if (last_rdata[0] && !hung) begin
                    $display("status still busy after %0d polls", POLL_LIMIT);
                    hung = 1'b1;
                end
            end else if (op == "X") begin
                for (int i = 0; i < addr && !hung; i++) begin
                    rng = xorshift(rng);
                    do_xfer(1'b0, PIX_BASE + 16'((rng % (FB_W * FB_H)) << 2), val, 1'b0, 1'b1);
                end
            end else begin
                $display("unknown operation %s in the pattern file", op);
                hung = 1'b1;
            end
        end
        if (cur_test != 0) report_test(cur_test);
        if (fd != 0) $fclose(fd);
        errors += line_draw_top_i.line_cmd_decode_i.line_draw_assertions_i.fail_count;
        $display("%0d tests run, %0d errors", tests_done, errors);
        if (errors == 0 && !hung && tests_done > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
gfx_pkg.sv
apb_pkg.sv
line_cmd_decode.sv
draw_line.sv
pixel_store.sv
line_draw_top.sv
line_draw_assertions.sv
line_draw_tb.sv

// ==== line_patterns.txt ====
# op addr data test, hex except test; W write, E write expecting pslverr, R read and compare,
# N read expecting pslverr, P poll status until idle, X read <addr> random pixels expecting data
W 0008 00000200 1
P 0000 00000000 1
X 0010 00000000 1
W 0000 00030002 2
W 0004 00030006 2
W 0008 00000105 2
P 0000 00000000 2
W 0000 0001000a 2
W 0004 0005000a 2
W 0008 00000107 2
P 0000 00000000 2
W 0000 00140014 2
W 0004 00180018 2
W 0008 00000109 2
P 0000 00000000 2
R 1310 00000005 2 (4,3)
R 131c 00000000 2 (7,3)
R 1328 00000007 2 (10,3)
R 1628 00000000 2 (10,6)
R 2658 00000009 2 (22,22)
R 265c 00000000 2 (23,22)
W 0000 000a0028 3
W 0004 000d001e 3
W 0008 00000103 3
P 0000 00000000 3
R 1a9c 00000003 3 (39,10)
R 1b98 00000003 3 (38,11)
R 1a98 00000000 3 (38,10)
R 1c80 00000003 3 (32,12)
R 1d78 00000003 3 (30,13)
W 0000 0002fffd 4
W 0004 00020003 4
W 0008 00000106 4
P 0000 00000000 4
R 1200 00000006 4 (0,2)
R 120c 00000006 4 (3,2)
R 12fc 00000000 4 (63,2)
R 12f4 00000000 4 (61,2)
W 0000 00280000 5
W 0004 0028003f 5
W 0008 00000102 5
R 0008 00000001 5
E 0008 0000010f 5
N 000c 00000000 5
P 0000 00000000 5
R 0008 00000000 5
R 38c8 00000002 5 (50,40)
W 0000 12345678 6
W 0004 abcd0011 6
R 0000 12345678 6
R 0004 abcd0011 6
